// File: hw/fdiv_pkg.sv
package fdiv_pkg;

        localparam int word_w = 65;
        localparam int frac_w = 52;
        localparam int exp_w = 12;
        localparam int exp_calc_w = 14;
        localparam int rem_w = 57;
        localparam int quo_w = 55;
        localparam int mant_rnd_w = 54;
        localparam int step_w = 6;
        localparam int class_w = 10;

        localparam logic [exp_calc_w-1:0] sp_bias = 14'd127;
        localparam logic [exp_calc_w-1:0] dp_bias = 14'd1023;
        localparam logic [exp_calc_w-1:0] sqrt_exp_offset = 14'd2045;

        localparam logic [step_w-1:0] div_first_step = 6'd54;
        localparam logic [step_w-1:0] sqrt_first_step = 6'd53;
        localparam logic [step_w-1:0] sp_last_step = 6'd29;
        localparam int denorm_max_shift = 54;

        // second operand of a square root, 1.0 in the recoded format.
        localparam logic [word_w-1:0] sqrt_divisor_one = 65'h07FF0000000000000;

        localparam int class_neg_inf = 0;
        localparam int class_neg_norm = 1;
        localparam int class_neg_sub = 2;
        localparam int class_neg_zero = 3;
        localparam int class_pos_zero = 4;
        localparam int class_pos_sub = 5;
        localparam int class_pos_norm = 6;
        localparam int class_pos_inf = 7;
        localparam int class_snan = 8;
        localparam int class_qnan = 9;

        typedef struct packed {
                logic fdiv;
                logic fsqrt;
        } fp_op_t;

        typedef struct packed {
                logic [word_w-1:0]  data1;
                logic [word_w-1:0]  data2;
                logic [class_w-1:0] class1;
                logic [class_w-1:0] class2;
                logic               fmt;   // 0 single, 1 double.
                logic [2:0]         rm;
        } fdiv_req_t;

        typedef struct packed {
                logic snan;
                logic qnan;
                logic dbz;
                logic infs;
                logic zero;
        } fdiv_flags_t;

        typedef struct packed {
                logic                  sig;
                logic [exp_calc_w-1:0] expo;
                logic [mant_rnd_w-1:0] mant;
                logic [2:0]            grs;
                logic                  fmt;
                logic [2:0]            rm;
                fdiv_flags_t           flags;
        } fdiv_rnd_t;

endpackage

// File: hw/fdiv_special_case.sv
`timescale 1ns/1ps

module fdiv_special_case import fdiv_pkg::*; (
        input  fp_op_t                  op_i,
        input  fdiv_req_t               req_i,
        output fdiv_flags_t             flags_o,
        output logic                    sign_o,
        output logic [exp_calc_w-1:0]   exponent_o,
        output logic [rem_w-1:0]        dividend_o,
        output logic [rem_w-1:0]        divisor_o,
        output logic                    is_sqrt_o
);

        logic [word_w-1:0]  data_a, data_b;
        logic [class_w-1:0] cls_a, cls_b;
        logic [exp_w-1:0]   exp_a, exp_b;
        logic               a_zero, a_inf, a_finite_nz;
        logic               b_zero, b_inf, b_finite;
        logic signed [exp_calc_w-1:0] sqrt_exp;

        assign is_sqrt_o = op_i.fsqrt;
        assign data_a = req_i.data1;
        assign cls_a = req_i.class1;
        assign data_b = op_i.fsqrt ? sqrt_divisor_one : req_i.data2;
        assign cls_b = op_i.fsqrt ? '0 : req_i.class2;

        assign exp_a = data_a[word_w-2 -: exp_w];
        assign exp_b = data_b[word_w-2 -: exp_w];

        assign a_zero = cls_a[class_neg_zero] | cls_a[class_pos_zero];
        assign a_inf = cls_a[class_neg_inf] | cls_a[class_pos_inf];
        assign a_finite_nz = cls_a[class_neg_norm] | cls_a[class_neg_sub] |
                             cls_a[class_pos_sub] | cls_a[class_pos_norm];
        assign b_zero = cls_b[class_neg_zero] | cls_b[class_pos_zero];
        assign b_inf = cls_b[class_neg_inf] | cls_b[class_pos_inf];
        assign b_finite = |cls_b[class_pos_norm:class_neg_norm];

        always_comb begin
                flags_o = '0;
                if (cls_a[class_snan] | cls_b[class_snan]) begin
                        flags_o.snan = 1'b1;
                end else if ((a_zero & b_zero) | (a_inf & b_inf)) begin
                        flags_o.snan = 1'b1; // 0/0 and inf/inf.
                end else if (cls_a[class_qnan] | cls_b[class_qnan]) begin
                        flags_o.qnan = 1'b1;
                end
                if (a_inf & b_finite) begin
                        flags_o.infs = 1'b1;
                end else if (b_zero & a_finite_nz) begin
                        flags_o.dbz = 1'b1;
                end
                flags_o.zero = a_zero | b_inf;
                if (op_i.fsqrt) begin
                        if (cls_a[class_pos_inf]) begin
                                flags_o.infs = 1'b1;
                        end
                        if (cls_a[class_neg_inf] | cls_a[class_neg_norm] | cls_a[class_neg_sub]) begin
                                flags_o.snan = 1'b1; // root of a negative.
                        end
                end
        end

        assign sign_o = data_a[word_w-1] ^ data_b[word_w-1];
        assign sqrt_exp = {2'b00, exp_a} - sqrt_exp_offset;

        always_comb begin
                exponent_o = {2'b00, exp_a} - {2'b00, exp_b};
                dividend_o = {5'h01, data_a[frac_w-1:0]};
                divisor_o = {4'h1, data_b[frac_w-1:0], 1'b0};
                if (op_i.fsqrt) begin
                        exponent_o = sqrt_exp >>> 1;
                        divisor_o = '0;
                        if (!exp_a[0]) begin
                                dividend_o = {dividend_o[rem_w-2:0], 1'b0}; // odd unbiased exponent.
                        end
                end
        end

endmodule

// File: hw/fdiv_ctrl.sv
`timescale 1ns/1ps

module fdiv_ctrl import fdiv_pkg::*; (
        input  logic                clock,
        input  logic                reset,
        input  fp_op_t              op_i,
        input  logic                fmt_i,
        output logic                load_o,
        output logic                step_o,
        output logic [step_w-1:0]   step_idx_o,
        output logic                finish_o,
        output logic                ready_o
);

        typedef enum logic [1:0] {
                st_idle,
                st_iter,
                st_finish,
                st_done
        } state_t;

        state_t             state_q;
        logic [step_w-1:0]  idx_q;
        logic               fmt_q;
        logic               last_step;

        // strobes while busy fall on the floor.
        assign load_o = (state_q == st_idle) & (op_i.fdiv | op_i.fsqrt);
        assign step_o = (state_q == st_iter);
        assign finish_o = (state_q == st_finish);
        assign ready_o = (state_q == st_done);
        assign step_idx_o = idx_q;

        // single precision needs only the upper quotient bits.
        assign last_step = (idx_q == '0) | (!fmt_q && idx_q == sp_last_step);

        always_ff @(posedge clock) begin
                if (!reset) begin
                        state_q <= st_idle;
                        idx_q <= '0;
                        fmt_q <= 1'b0;
                end else begin
                        case (state_q)
                                st_idle: begin
                                        if (load_o) begin
                                                state_q <= st_iter;
                                                fmt_q <= fmt_i;
                                                idx_q <= op_i.fsqrt ? sqrt_first_step
                                                                    : div_first_step;
                                        end
                                end
                                st_iter: begin
                                        if (last_step) begin
                                                state_q <= st_finish;
                                        end else begin
                                                idx_q <= idx_q - 1'b1;
                                        end
                                end
                                st_finish: begin
                                        state_q <= st_done;
                                end
                                default: begin
                                        state_q <= st_idle;
                                end
                        endcase
                end
        end

endmodule

// File: hw/fdiv_iter.sv
`timescale 1ns/1ps

module fdiv_iter import fdiv_pkg::*; (
        input  logic                clock,
        input  logic                reset,
        input  logic                load_i,
        input  logic                step_i,
        input  logic [step_w-1:0]   step_idx_i,
        input  logic                is_sqrt_i,
        input  logic [rem_w-1:0]    dividend_i,
        input  logic [rem_w-1:0]    divisor_i,
        output logic [quo_w-1:0]    quotient_o,
        output logic [rem_w-1:0]    remainder_o
);

        logic [quo_w-1:0]   quo_q;
        logic [rem_w-1:0]   rem_q;
        logic [rem_w-1:0]   div_q;
        logic               sqrt_q;

        logic [rem_w-1:0]   rem_shift;
        logic [rem_w-1:0]   trial;
        logic [rem_w-1:0]   diff;
        logic               fits;

        assign rem_shift = {rem_q[rem_w-2:0], 1'b0};

        // square root subtracts the root so far with the new bit set.
        always_comb begin
                if (sqrt_q) begin
                        trial = {1'b0, quo_q, 1'b0} | (rem_w'(1) << step_idx_i);
                end else begin
                        trial = div_q;
                end
        end

        assign diff = rem_shift - trial;
        assign fits = !diff[rem_w-1]; // non-negative difference.

        always_ff @(posedge clock) begin
                if (!reset) begin
                        sqrt_q <= 1'b0;
                        quo_q <= '0;
                end else if (load_i) begin
                        sqrt_q <= is_sqrt_i;
                        quo_q <= '0;
                end else if (step_i && fits) begin
                        quo_q[step_idx_i] <= 1'b1;
                end
        end

        always_ff @(posedge clock) begin
                if (load_i) begin
                        rem_q <= dividend_i;
                        div_q <= divisor_i;
                end else if (step_i) begin
                        rem_q <= fits ? diff : rem_shift;
                end
        end

        assign quotient_o = quo_q;
        assign remainder_o = rem_q;

endmodule

// File: hw/fdiv_norm.sv
`timescale 1ns/1ps

module fdiv_norm import fdiv_pkg::*; (
        input  logic                    clock,
        input  logic                    reset,
        input  logic                    load_i,
        input  logic                    finish_i,
        input  logic                    fmt_i,
        input  logic [2:0]              rm_i,
        input  fdiv_flags_t             flags_i,
        input  logic                    sign_i,
        input  logic [exp_calc_w-1:0]   exponent_i,
        input  logic [quo_w-1:0]        quotient_i,
        input  logic [rem_w-1:0]        remainder_i,
        output fdiv_rnd_t               result_o
);

        logic                           fmt_q;
        logic [2:0]                     rm_q;
        fdiv_flags_t                    flags_q;
        logic                           sign_q;
        logic signed [exp_calc_w-1:0]   exp_q;

        // quotient, remainder and room for the subnormal shift.
        logic [164:0]                   mant_cat, mant_norm, mant_shift;
        logic                           lead_zero;
        logic signed [exp_calc_w-1:0]   exp_norm;
        logic [exp_calc_w-1:0]          exp_rnd;
        logic [step_w-1:0]              shift_amt;
        fdiv_rnd_t                      result_d, result_q;

        always_ff @(posedge clock) begin
                if (load_i) begin
                        fmt_q <= fmt_i;
                        rm_q <= rm_i;
                        flags_q <= flags_i;
                        sign_q <= sign_i;
                        exp_q <= exponent_i;
                end
        end

        always_comb begin
                mant_cat = {quotient_i, remainder_i[rem_w-2:0], {denorm_max_shift{1'b0}}};
                lead_zero = !mant_cat[164];
                mant_norm = lead_zero ? {mant_cat[163:0], 1'b0} : mant_cat;

                exp_norm = exp_q + (fmt_q ? dp_bias : sp_bias) - {13'h0, lead_zero};
                exp_rnd = exp_norm;
                shift_amt = '0;
                if (exp_norm <= 0) begin
                        shift_amt = step_w'(denorm_max_shift); // flushes everything.
                        if (exp_norm > -denorm_max_shift) begin
                                shift_amt = step_w'(1 - exp_norm);
                        end
                        exp_rnd = '0;
                end
                mant_shift = mant_norm >> shift_amt;

                result_d.sig = sign_q;
                result_d.expo = exp_rnd;
                result_d.fmt = fmt_q;
                result_d.rm = rm_q;
                result_d.flags = flags_q;
                if (fmt_q) begin
                        result_d.mant = {1'b0, mant_shift[164:112]};
                        result_d.grs = {mant_shift[111:110], |mant_shift[109:0]};
                end else begin
                        result_d.mant = {30'h0, mant_shift[164:141]};
                        result_d.grs = {mant_shift[140:139], |mant_shift[138:0]};
                end
        end

        always_ff @(posedge clock) begin
                if (!reset) begin
                        result_q <= '0;
                end else if (finish_i) begin
                        result_q <= result_d;
                end
        end

        assign result_o = result_q;

endmodule

// File: hw/fdiv_top.sv
`timescale 1ns/1ps

module fdiv_top import fdiv_pkg::*; (
        input  logic        clock,
        input  logic        reset,
        input  fp_op_t      op_i,
        input  fdiv_req_t   req_i,
        output fdiv_rnd_t   result_o,
        output logic        ready_o
);

        fdiv_flags_t            flags;
        logic                   sign;
        logic [exp_calc_w-1:0]  exponent;
        logic [rem_w-1:0]       dividend;
        logic [rem_w-1:0]       divisor;
        logic                   is_sqrt;

        logic                   load;
        logic                   step;
        logic [step_w-1:0]      step_idx;
        logic                   finish;

        logic [quo_w-1:0]       quotient;
        logic [rem_w-1:0]       remainder;

        fdiv_special_case u_special_case (
                .op_i       (op_i),
                .req_i      (req_i),
                .flags_o    (flags),
                .sign_o     (sign),
                .exponent_o (exponent),
                .dividend_o (dividend),
                .divisor_o  (divisor),
                .is_sqrt_o  (is_sqrt)
        );

        fdiv_ctrl u_ctrl (
                .clock      (clock),
                .reset      (reset),
                .op_i       (op_i),
                .fmt_i      (req_i.fmt),
                .load_o     (load),
                .step_o     (step),
                .step_idx_o (step_idx),
                .finish_o   (finish),
                .ready_o    (ready_o)
        );

        fdiv_iter u_iter (
                .clock       (clock),
                .reset       (reset),
                .load_i      (load),
                .step_i      (step),
                .step_idx_i  (step_idx),
                .is_sqrt_i   (is_sqrt),
                .dividend_i  (dividend),
                .divisor_i   (divisor),
                .quotient_o  (quotient),
                .remainder_o (remainder)
        );

        fdiv_norm u_norm (
                .clock       (clock),
                .reset       (reset),
                .load_i      (load),
                .finish_i    (finish),
                .fmt_i       (req_i.fmt),
                .rm_i        (req_i.rm),
                .flags_i     (flags),
                .sign_i      (sign),
                .exponent_i  (exponent),
                .quotient_i  (quotient),
                .remainder_i (remainder),
                .result_o    (result_o)
        );

endmodule

// File: dv/fdiv_tb_model.svh
function automatic fdiv_flags_t predict_flags(input logic is_sqrt, input logic [9:0] c1,
                                              input logic [9:0] c2_in);
        fdiv_flags_t f;
        logic [9:0] c2;
        logic az, ai, afnz, bz, bi, bfin;
        c2 = is_sqrt ? 10'h0 : c2_in; // root has no second operand.
        az = c1[class_neg_zero] | c1[class_pos_zero];
        ai = c1[class_neg_inf] | c1[class_pos_inf];
        afnz = c1[class_neg_norm] | c1[class_neg_sub] | c1[class_pos_sub] | c1[class_pos_norm];
        bz = c2[class_neg_zero] | c2[class_pos_zero];
        bi = c2[class_neg_inf] | c2[class_pos_inf];
        bfin = bz | c2[class_neg_norm] | c2[class_neg_sub] | c2[class_pos_sub] |
               c2[class_pos_norm];
        f.snan = c1[class_snan] | c2[class_snan] | (az & bz) | (ai & bi) |
                 (is_sqrt & (c1[class_neg_inf] | c1[class_neg_norm] | c1[class_neg_sub]));
        f.qnan = !f.snan & (c1[class_qnan] | c2[class_qnan]);
        f.infs = (ai & bfin) | (is_sqrt & c1[class_pos_inf]);
        f.dbz = !(ai & bfin) & bz & afnz;
        f.zero = az | bi;
        return f;
endfunction

function automatic logic [127:0] int_sqrt(input logic [127:0] y);
        logic [127:0] r, t;
        r = '0;
        for (int b = 63; b >= 0; b--) begin
                t = r | (128'd1 << b);
                if (t * t <= y) r = t;
        end
        return r;
endfunction

function automatic int expected_latency(input logic is_sqrt, input logic fmt);
        if (is_sqrt) return fmt ? 54 + 2 : 25 + 2;
        return fmt ? 55 + 2 : 26 + 2;
endfunction

function automatic fdiv_rnd_t predict_result(input logic is_sqrt, input fdiv_req_t req);
        fdiv_rnd_t r;
        logic [127:0] ma, mb, x, num, q, v;
        logic st, lz;
        int ea, eb, e, s, n, lsb, mw;
        r = '0;
        ma = {75'h0, 1'b1, req.data1[51:0]};
        mb = {75'h0, 1'b1, req.data2[51:0]};
        ea = int'(req.data1[63:52]);
        eb = int'(req.data2[63:52]);
        if (!is_sqrt) begin
                n = req.fmt ? 55 : 26; // quotient bits produced.
                num = ma << (n - 1);
                q = (num / mb) << (55 - n);
                st = (num % mb) != 0;
                e = ea - eb;
                r.sig = req.data1[64] ^ req.data2[64];
        end else begin
                lsb = req.fmt ? 0 : 29;
                x = req.data1[52] ? ma : ma << 1; // odd unbiased exponent doubles.
                q = int_sqrt((x << 54) >> (2 * lsb)) << lsb;
                st = (q * q) != (x << 54);
                e = (ea - 2045) >>> 1;
                r.sig = req.data1[64];
        end
        lz = !q[54];
        if (lz) q = q << 1;
        e = e + (req.fmt ? 1023 : 127) - int'(lz);
        s = 0;
        if (e <= 0) begin
                s = (e > -54) ? 1 - e : 54;
                e = 0;
        end
        v = (((q << 1) | 128'(st)) << 54) >> s;
        mw = req.fmt ? 53 : 24;
        r.mant = 54'(v >> (110 - mw));
        r.grs = {v[109 - mw], v[108 - mw], |(v & ((128'd1 << (108 - mw)) - 1))};
        r.expo = 14'(e);
        r.fmt = req.fmt;
        r.rm = req.rm;
        r.flags = predict_flags(is_sqrt, req.class1, req.class2);
        return r;
endfunction

// File: dv/fdiv_tb.sv
`timescale 1ns/1ps

module fdiv_tb import fdiv_pkg::*; ();

        `include "fdiv_tb_model.svh"

        localparam int max_ops = 40;
        localparam int op_cycles = 60;

        logic       clock = 1'b0;
        logic       reset;
        fp_op_t     op_i;
        fdiv_req_t  req_i;
        fdiv_rnd_t  result_o;
        logic       ready_o;

        int         errors = 0;
        int         cyc = 0;
        int         lat_cnt = 0;
        logic       busy_q = 1'b0;
        string      test_name = "reset";
        fdiv_rnd_t  exp_res = '0;
        int         exp_lat = 0;
        logic       check_data = 1'b0;

        fdiv_top u_dut (
                .clock    (clock),
                .reset    (reset),
                .op_i     (op_i),
                .req_i    (req_i),
                .result_o (result_o),
                .ready_o  (ready_o)
        );

        always #50 clock = ~clock;

        // cycles since the accepted strobe.
        always @(posedge clock) begin
                cyc <= cyc + 1;
                if (!reset) begin
                        busy_q <= 1'b0;
                        lat_cnt <= 0;
                end else if (busy_q && ready_o) begin
                        busy_q <= 1'b0;
                end else if (!busy_q && (op_i.fdiv | op_i.fsqrt)) begin
                        busy_q <= 1'b1;
                        lat_cnt <= 1;
                end else begin
                        lat_cnt <= lat_cnt + 1;
                end
        end

        assert property (@(posedge clock) (cyc >= 1 && cyc <= 4) |-> !ready_o)
                else begin
                        errors++;
                        $display("ready_o high during or right after reset");
                end
        assert property (@(posedge clock) disable iff (!reset) ready_o |-> busy_q)
                else begin
                        errors++;
                        $display("ready_o without an accepted operation");
                end
        assert property (@(posedge clock) disable iff (!reset) ready_o |-> lat_cnt == exp_lat)
                else begin
                        errors++;
                        $display("MISMATCH %s latency expected %0d actual %0d",
                                 test_name, exp_lat, $sampled(lat_cnt));
                end
        assert property (@(posedge clock) disable iff (!reset)
                         ready_o |-> result_o.flags == exp_res.flags)
                else begin
                        errors++;
                        $display("MISMATCH %s flags expected %b actual %b",
                                 test_name, exp_res.flags, result_o.flags);
                end
        assert property (@(posedge clock) disable iff (!reset)
                         ready_o |-> result_o.fmt == exp_res.fmt && result_o.rm == exp_res.rm)
                else begin
                        errors++;
                        $display("MISMATCH %s fmt/rm expected %b/%0d actual %b/%0d", test_name,
                                 exp_res.fmt, exp_res.rm, result_o.fmt, result_o.rm);
                end
        assert property (@(posedge clock) disable iff (!reset)
                         ready_o && check_data |-> result_o.expo == exp_res.expo)
                else begin
                        errors++;
                        $display("MISMATCH %s expo expected %h actual %h",
                                 test_name, exp_res.expo, result_o.expo);
                end
        assert property (@(posedge clock) disable iff (!reset)
                         ready_o && check_data |-> result_o.mant == exp_res.mant)
                else begin
                        errors++;
                        $display("MISMATCH %s mant expected %h actual %h",
                                 test_name, exp_res.mant, result_o.mant);
                end
        assert property (@(posedge clock) disable iff (!reset)
                         ready_o && check_data |-> result_o.grs == exp_res.grs &&
                                                   result_o.sig == exp_res.sig)
                else begin
                        errors++;
                        $display("MISMATCH %s sig/grs expected %b/%b actual %b/%b", test_name,
                                 exp_res.sig, exp_res.grs, result_o.sig, result_o.grs);
                end

        function automatic fdiv_req_t make_req(input logic s1, input int e1, input logic [51:0] f1,
                                               input logic s2, input int e2, input logic [51:0] f2,
                                               input logic fmt);
                fdiv_req_t r;
                r.data1 = {s1, 12'(e1), f1};
                r.data2 = {s2, 12'(e2), f2};
                r.class1 = 10'(1) << (s1 ? class_neg_norm : class_pos_norm);
                r.class2 = 10'(1) << (s2 ? class_neg_norm : class_pos_norm);
                r.fmt = fmt;
                r.rm = 3'd0;
                return r;
        endfunction

        task automatic wait_ready(input int limit);
                int k;
                k = 0;
                @(negedge clock);
                while (!ready_o && k < limit) begin
                        @(negedge clock);
                        k++;
                end
                if (!ready_o) begin
                        errors++;
                        $display("ready_o never rose for %s", test_name);
                end
        endtask

        task automatic run_op(input string name, input logic is_sqrt, input fdiv_req_t req,
                              input logic data_chk);
                fp_op_t o;
                o.fdiv = !is_sqrt;
                o.fsqrt = is_sqrt;
                @(posedge clock);
                @(negedge clock);
                test_name = name;
                exp_res = predict_result(is_sqrt, req);
                exp_lat = expected_latency(is_sqrt, req.fmt);
                check_data = data_chk;
                @(posedge clock);
                op_i <= o;
                req_i <= req;
                @(posedge clock);
                op_i <= '0;
                wait_ready(80);
        endtask

        // special case operand with a forced class.
        task automatic run_special(input string name, input logic is_sqrt,
                                   input int c1, input int c2);
                fdiv_req_t r;
                r = make_req(1'b0, 2047, 52'h0, 1'b0, 2047, 52'h0, 1'b1);
                r.class1 = 10'(1) << c1;
                r.class2 = 10'(1) << c2;
                r.rm = 3'($urandom());
                run_op(name, is_sqrt, r, 1'b0);
        endtask

        initial begin
                #(max_ops * op_cycles * 100 + 50000);
                $display("watchdog expired, the run did not finish in time");
                $display("Errors found");
                $finish;
        end

        initial begin
                fdiv_req_t r;
                logic [63:0] f1, f2;
                logic s1, s2;
                int e1, e2;
                void'($urandom(32'h4e37_4184));
                reset = 1'b0;
                op_i = '0;
                req_i = '0;
                repeat (3) @(posedge clock);
                reset <= 1'b1;

                run_special("snan", 1'b0, class_snan, class_pos_norm);
                run_special("qnan", 1'b0, class_pos_norm, class_qnan);
                run_special("zero_zero", 1'b0, class_pos_zero, class_neg_zero);
                run_special("inf_inf", 1'b0, class_pos_inf, class_neg_inf);
                run_special("x_zero", 1'b0, class_pos_norm, class_pos_zero);
                run_special("inf_x", 1'b0, class_neg_inf, class_pos_norm);
                run_special("sqrt_neg", 1'b1, class_neg_norm, class_pos_norm);
                run_special("sqrt_pinf", 1'b1, class_pos_inf, class_pos_norm);

                for (int fmt = 0; fmt < 2; fmt++) begin
                        r = make_req(1'b0, 2049, 52'h8_0000_0000_0000, 1'b0, 2048,
                                     52'h8_0000_0000_0000, fmt[0]);
                        run_op("div_6_3", 1'b0, r, 1'b1);
                        r = make_req(1'b0, 2047, 52'h0, 1'b0, 2049, 52'h0, fmt[0]);
                        run_op("div_1_4", 1'b0, r, 1'b1);
                        r = make_req(1'b0, 2049, 52'h0, 1'b0, 2047, 52'h0, fmt[0]);
                        run_op("sqrt_4", 1'b1, r, 1'b1);
                end

                for (int i = 0; i < 12; i++) begin
                        f1 = {$urandom(), $urandom()};
                        f2 = {$urandom(), $urandom()};
                        s1 = $urandom() % 2;
                        s2 = $urandom() % 2;
                        e1 = 2047 + int'($urandom() % 120) - 60;
                        e2 = 2047 + int'($urandom() % 120) - 60;
                        if (i % 3 == 2) begin
                                e1 = 2047 + int'($urandom() % 200) - 100;
                                r = make_req(1'b0, e1, f1[51:0], 1'b0, 2047, f2[51:0], i[0]);
                                r.rm = 3'($urandom());
                                run_op("rand_sqrt", 1'b1, r, 1'b1);
                        end else begin
                                r = make_req(s1, e1, f1[51:0], s2, e2, f2[51:0], i[0]);
                                r.rm = 3'($urandom());
                                run_op("rand_div", 1'b0, r, 1'b1);
                        end
                end

                // quotients under the normal range and two past the cap.
                f1 = {$urandom(), $urandom()};
                f2 = {$urandom(), $urandom()};
                r = make_req(1'b0, 1017, f1[51:0], 1'b1, 2047, f2[51:0], 1'b1);
                run_op("denorm_dp", 1'b0, r, 1'b1);
                r = make_req(1'b0, 900, f1[51:0], 1'b0, 2047, f2[51:0], 1'b1);
                run_op("denorm_dp_cap", 1'b0, r, 1'b1);
                r = make_req(1'b1, 1912, f1[51:0], 1'b0, 2047, f2[51:0], 1'b0);
                run_op("denorm_sp", 1'b0, r, 1'b1);
                r = make_req(1'b0, 1700, f1[51:0], 1'b0, 2047, f2[51:0], 1'b0);
                run_op("denorm_sp_cap", 1'b0, r, 1'b1);

                // second strobe lands while the first divide runs.
                r = make_req(1'b0, 2050, f1[51:0], 1'b0, 2046, f2[51:0], 1'b1);
                r.rm = 3'd5;
                @(posedge clock);
                @(negedge clock);
                test_name = "busy";
                exp_res = predict_result(1'b0, r);
                exp_lat = expected_latency(1'b0, 1'b1);
                check_data = 1'b1;
                @(posedge clock);
                op_i <= '{fdiv: 1'b1, fsqrt: 1'b0};
                req_i <= r;
                @(posedge clock);
                op_i <= '0;
                repeat (5) @(posedge clock);
                op_i <= '{fdiv: 1'b0, fsqrt: 1'b1};
                req_i <= make_req(1'b0, 2047, f2[51:0], 1'b0, 2047, f1[51:0], 1'b0);
                @(posedge clock);
                op_i <= '0;
                wait_ready(80);
                repeat (70) @(posedge clock);

                $display("run complete, %0d errors", errors);
                if (errors == 0) begin
                        $display("No errors");
                end else begin
                        $display("Errors found");
                end
                $finish;
        end

endmodule

// File: compile.f
+incdir+dv
hw/fdiv_pkg.sv
hw/fdiv_special_case.sv
hw/fdiv_ctrl.sv
hw/fdiv_iter.sv
hw/fdiv_norm.sv
hw/fdiv_top.sv
dv/fdiv_tb.sv

// File: Bender.yml
package:
  name: fdiv

sources:
  - files:
      - hw/fdiv_pkg.sv
      - hw/fdiv_special_case.sv
      - hw/fdiv_ctrl.sv
      - hw/fdiv_iter.sv
      - hw/fdiv_norm.sv
      - hw/fdiv_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/fdiv_tb.sv
